// File: sources.f
+incdir+include
source/route_pkg.sv
source/route_table.sv
source/port_ingress.sv
source/tx_arbiter.sv
source/route_core.sv
verification/route_core_tb.sv

// File: verification/route_core_tb.sv
`default_nettype none
`timescale 1ns/1ns
`include "route_cfg.svh"

module route_core_tb;

	localparam int NETH = `ROUTE_NETH;
	localparam int NTBL = 2**`ROUTE_LGTBL;
	localparam int NQ = NETH*NETH;
	localparam int DEPTH = 256;
	// Phase 6 packets per port
	localparam int NP6 = 10;
	// Phases 1 to 5 and the relearn round before phase 6
	localparam int NPKT = 17 + NETH*NP6;
	localparam int LIMIT = NPKT*40 + 2000;

	logic				i_clk = 1'b0;
	logic				i_reset;
	route_pkg::port_mask_t		i_rx_valid;
	route_pkg::beat_t		i_rx_data [0:NETH-1];
	route_pkg::port_mask_t		i_rx_last;
	route_pkg::port_mask_t		i_tx_ready;
	wire route_pkg::port_mask_t	o_rx_ready;
	wire route_pkg::port_mask_t	o_tx_valid;
	wire route_pkg::beat_t		o_tx_data [0:NETH-1];
	wire route_pkg::port_mask_t	o_tx_last;

	// Reference table
	logic [NTBL-1:0]		tbl_valid;
	route_pkg::mac_t		tbl_mac [0:NTBL-1];
	route_pkg::port_idx_t		tbl_port [0:NTBL-1];
	route_pkg::tbl_idx_t		tbl_ptr;

	// Beats waiting to enter each input
	route_pkg::beat_t		rx_mem [0:NETH-1][0:DEPTH-1];
	logic				rx_lmem [0:NETH-1][0:DEPTH-1];
	int				rx_wr [0:NETH-1];
	int				rx_rd [0:NETH-1];
	// Expected beats with queue index output*NETH + input
	route_pkg::beat_t		exp_data [0:NQ-1][0:DEPTH-1];
	logic				exp_last [0:NQ-1][0:DEPTH-1];
	int				exp_wr [0:NQ-1];
	int				exp_rd [0:NQ-1];
	// Packet in flight on each output
	logic				in_pkt [0:NETH-1];
	route_pkg::port_idx_t		owner [0:NETH-1];
	// Beat offered without ready in the previous cycle
	logic				stall [0:NETH-1];
	route_pkg::beat_t		stall_data [0:NETH-1];
	logic				stall_last [0:NETH-1];
	int				cycles = 0;

	route_core uut (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_rx_valid(i_rx_valid), .o_rx_ready(o_rx_ready),
		.i_rx_data(i_rx_data), .i_rx_last(i_rx_last),
		.o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
		.o_tx_data(o_tx_data), .o_tx_last(o_tx_last)
	);

	always #5 i_clk = ~i_clk;

	////////////////////
	// Checks
	////////////////////

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped on first error");
	endtask

	task automatic check_beat(input route_pkg::beat_t got, input route_pkg::beat_t exp,
			input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_port(input route_pkg::port_idx_t got,
			input route_pkg::port_idx_t exp, input string what);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Locally administered station addresses
	function automatic route_pkg::mac_t station_mac(input int n);
		return {16'h0200, 32'(n)};
	endfunction

	// Broadcast never hits and the last match wins
	task automatic find_station(input route_pkg::mac_t mac, output logic hit,
			output route_pkg::port_idx_t port);
		hit = 1'b0;
		port = '0;
		for (int e = 0; e < NTBL; e++)
		begin
			if (tbl_valid[e] && tbl_mac[e] == mac && mac != route_pkg::MAC_BROADCAST)
			begin
				hit = 1'b1;
				port = tbl_port[e];
			end
		end
	endtask

	// Move a known station in place or replace the oldest slot
	task automatic learn_station(input route_pkg::mac_t mac, input route_pkg::port_idx_t port);
		logic hit;
		route_pkg::port_idx_t old;
		find_station(mac, hit, old);
		if (hit)
		begin
			for (int e = 0; e < NTBL; e++)
				if (tbl_valid[e] && tbl_mac[e] == mac)
					tbl_port[e] = port;
		end else
		begin
			tbl_valid[tbl_ptr] = 1'b1;
			tbl_mac[tbl_ptr] = mac;
			tbl_port[tbl_ptr] = port;
			tbl_ptr = tbl_ptr + 1'b1;
		end
	endtask

	// Queue a packet on input p and predict where its beats go
	// Length 0 picks a random length of 1 to 6
	task automatic send_pkt(input route_pkg::port_idx_t p, input route_pkg::mac_t dst,
			input route_pkg::mac_t src, input int len);
		route_pkg::beat_t b;
		route_pkg::port_mask_t mask;
		route_pkg::port_idx_t hport;
		logic hit;
		int n;
		int q;
		n = (len > 0) ? len : 1 + $urandom % 6;
		find_station(dst, hit, hport);
		if (hit)
			mask = (hport == p) ? '0 : route_pkg::port_mask_t'(1) << hport;
		else
			mask = ~(route_pkg::port_mask_t'(1) << p);
		for (int k = 0; k < n; k++)
		begin
			b = {$urandom, $urandom, $urandom, $urandom};
			if (k == 0)
				b[`ROUTE_PKTDW-1 -: 2*`ROUTE_MACW] = {dst, src};
			// Low byte tags the input port
			b[7:0] = 8'(p);
			rx_mem[p][rx_wr[p] % DEPTH] = b;
			rx_lmem[p][rx_wr[p] % DEPTH] = (k == n-1);
			rx_wr[p]++;
			for (int j = 0; j < NETH; j++)
			begin
				if (mask[j])
				begin
					q = j*NETH + p;
					exp_data[q][exp_wr[q] % DEPTH] = b;
					exp_last[q][exp_wr[q] % DEPTH] = (k == n-1);
					exp_wr[q]++;
				end
			end
		end
		learn_station(src, p);
	endtask

	function automatic logic all_idle();
		logic idle;
		idle = (i_rx_valid == '0);
		for (int p = 0; p < NETH; p++)
			if (rx_rd[p] != rx_wr[p])
				idle = 1'b0;
		for (int q = 0; q < NQ; q++)
			if (exp_rd[q] != exp_wr[q])
				idle = 1'b0;
		return idle;
	endfunction

	task automatic wait_drain();
		do
			@(posedge i_clk);
		while (!all_idle());
		repeat (2) @(posedge i_clk);
	endtask

	task automatic send_and_drain(input int p, input route_pkg::mac_t dst,
			input route_pkg::mac_t src, input int len);
		@(negedge i_clk);
		send_pkt(route_pkg::port_idx_t'(p), dst, src, len);
		wait_drain();
	endtask

	////////////////////
	// Drive and monitor
	////////////////////

	// Present the next queued beat on every input
	always @(posedge i_clk)
	begin
		for (int p = 0; p < NETH; p++)
		begin
			if (rx_rd[p] != rx_wr[p])
			begin
				i_rx_valid[p] <= 1'b1;
				i_rx_data[p] <= rx_mem[p][rx_rd[p] % DEPTH];
				i_rx_last[p] <= rx_lmem[p][rx_rd[p] % DEPTH];
			end else
				i_rx_valid[p] <= 1'b0;
		end
		i_tx_ready <= route_pkg::port_mask_t'($urandom);
	end

	// Note mid cycle the beats that transfer at the next edge
	always @(negedge i_clk)
	begin : monitor
		route_pkg::port_idx_t tag;
		int q;
		for (int p = 0; p < NETH; p++)
			if (i_rx_valid[p] && o_rx_ready[p])
				rx_rd[p]++;
		for (int j = 0; j < NETH; j++)
		begin
			// A stalled output keeps offering the same beat
			if (stall[j])
			begin
				check_last(o_tx_valid[j], 1'b1,
						$sformatf("output %0d valid held", j));
				check_beat(o_tx_data[j], stall_data[j],
						$sformatf("output %0d data held", j));
				check_last(o_tx_last[j], stall_last[j],
						$sformatf("output %0d last held", j));
			end
			stall[j] = o_tx_valid[j] && !i_tx_ready[j];
			stall_data[j] = o_tx_data[j];
			stall_last[j] = o_tx_last[j];
			if (o_tx_valid[j] && i_tx_ready[j])
			begin
				tag = route_pkg::port_idx_t'(o_tx_data[j][7:0]);
				// No interleaving inside a packet
				if (in_pkt[j])
					check_port(tag, owner[j], $sformatf("output %0d source", j));
				q = j*NETH + tag;
				if (exp_rd[q] == exp_wr[q])
				begin
					$display("Output %0d sent a beat from port %0d that was not expected",
							j, tag);
					abort_run();
				end
				check_beat(o_tx_data[j], exp_data[q][exp_rd[q] % DEPTH],
						$sformatf("output %0d data", j));
				check_last(o_tx_last[j], exp_last[q][exp_rd[q] % DEPTH],
						$sformatf("output %0d last", j));
				exp_rd[q]++;
				in_pkt[j] = !o_tx_last[j];
				owner[j] = tag;
			end
		end
	end

	always @(posedge i_clk)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("Timeout, the run did not finish within %0d cycles", LIMIT);
			abort_run();
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		int r;
		route_pkg::mac_t dst;
		void'($urandom(2));
		i_reset = 1'b1;
		i_rx_valid = '0;
		i_rx_last = '0;
		i_tx_ready = '0;
		tbl_valid = '0;
		tbl_ptr = '0;
		for (int p = 0; p < NETH; p++)
		begin
			i_rx_data[p] = '0;
			rx_wr[p] = 0;
			rx_rd[p] = 0;
			in_pkt[p] = 1'b0;
			owner[p] = '0;
			stall[p] = 1'b0;
			stall_data[p] = '0;
			stall_last[p] = 1'b0;
		end
		for (int q = 0; q < NQ; q++)
		begin
			exp_wr[q] = 0;
			exp_rd[q] = 0;
		end
		repeat (16) @(posedge i_clk);
		i_reset <= 1'b0;
		@(negedge i_clk);
		if (o_tx_valid !== '0 || o_rx_ready !== '1)
		begin
			$display("Outputs not idle after reset");
			abort_run();
		end

		// Phase 1 floods unknown and broadcast destinations
		send_and_drain(0, station_mac(100), station_mac(0), 0);
		send_and_drain(1, route_pkg::MAC_BROADCAST, station_mac(1), 0);
		// Phase 2 sends learned destinations to one port
		send_and_drain(2, station_mac(0), station_mac(2), 0);
		send_and_drain(3, station_mac(1), station_mac(3), 0);
		// Phase 3 drops an own port destination and the next packet passes
		send_and_drain(0, station_mac(0), station_mac(4), 3);
		send_and_drain(0, station_mac(1), station_mac(0), 0);
		// Phase 4 moves station 1 to port 2
		send_and_drain(2, route_pkg::MAC_BROADCAST, station_mac(1), 0);
		send_and_drain(3, station_mac(1), station_mac(3), 0);
		// In phase 5 the ninth MAC evicts the oldest entry
		for (int n = 10; n < 14; n++)
			send_and_drain(1, route_pkg::MAC_BROADCAST, station_mac(n), 0);
		send_and_drain(3, station_mac(0), station_mac(3), 0);
		// Every station back on its own port
		for (int p = 0; p < NETH; p++)
			send_and_drain(p, route_pkg::MAC_BROADCAST, station_mac(p), 0);

		// Phase 6 drives all ports at once
		// Floods here are one beat long
		// Two long floods can hold each other's outputs forever
		@(negedge i_clk);
		for (int n = 0; n < NP6; n++)
		begin
			for (int p = 0; p < NETH; p++)
			begin
				r = $urandom % NETH;
				dst = (r == p) ? route_pkg::MAC_BROADCAST : station_mac(r);
				send_pkt(route_pkg::port_idx_t'(p), dst, station_mac(p), (r == p) ? 1 : 0);
			end
		end
		wait_drain();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/route_core.sv
`default_nettype none
`timescale 1ns/1ns
`include "route_cfg.svh"

module route_core (
	input  wire				i_clk,
	input  wire				i_reset,
	// Receive streams
	input  wire route_pkg::port_mask_t	i_rx_valid,
	output wire route_pkg::port_mask_t	o_rx_ready,
	input  wire route_pkg::beat_t		i_rx_data [0:`ROUTE_NETH-1],
	input  wire route_pkg::port_mask_t	i_rx_last,
	// Transmit streams
	output wire route_pkg::port_mask_t	o_tx_valid,
	input  wire route_pkg::port_mask_t	i_tx_ready,
	output wire route_pkg::beat_t		o_tx_data [0:`ROUTE_NETH-1],
	output wire route_pkg::port_mask_t	o_tx_last
);

	// Table traffic
	wire route_pkg::port_mask_t	learn_req;
	wire route_pkg::mac_t		learn_mac [0:`ROUTE_NETH-1];
	wire route_pkg::port_mask_t	learn_ack;
	wire route_pkg::mac_t		lkup_mac [0:`ROUTE_NETH-1];
	wire route_pkg::port_mask_t	lkup_hit;
	wire route_pkg::port_idx_t	lkup_port [0:`ROUTE_NETH-1];

	// Fan-out matrix, indexed by ingress then output
	wire route_pkg::port_mask_t	ing_req [0:`ROUTE_NETH-1];
	wire route_pkg::port_mask_t	ing_take [0:`ROUTE_NETH-1];
	// Same matrix seen from the outputs
	wire route_pkg::port_mask_t	arb_req [0:`ROUTE_NETH-1];
	wire route_pkg::port_mask_t	arb_take [0:`ROUTE_NETH-1];
	wire route_pkg::beat_t		fwd_data [0:`ROUTE_NETH-1];
	wire route_pkg::port_mask_t	fwd_last;

	route_table u_table (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_learn_req(learn_req), .i_learn_mac(learn_mac), .o_learn_ack(learn_ack),
		.i_lkup_mac(lkup_mac), .o_lkup_hit(lkup_hit), .o_lkup_port(lkup_port)
	);

	for (genvar gp = 0; gp < `ROUTE_NETH; gp++)
	begin : g_port
		port_ingress #(.PORT(gp)) u_ingress (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_rx_valid(i_rx_valid[gp]), .i_rx_data(i_rx_data[gp]),
			.i_rx_last(i_rx_last[gp]), .o_rx_ready(o_rx_ready[gp]),
			.o_learn_req(learn_req[gp]), .o_learn_mac(learn_mac[gp]),
			.i_learn_ack(learn_ack[gp]),
			.o_lkup_mac(lkup_mac[gp]), .i_lkup_hit(lkup_hit[gp]),
			.i_lkup_port(lkup_port[gp]),
			.o_fwd_req(ing_req[gp]), .o_fwd_data(fwd_data[gp]),
			.o_fwd_last(fwd_last[gp]), .i_fwd_take(ing_take[gp])
		);

		tx_arbiter u_arbiter (
			.i_clk(i_clk), .i_reset(i_reset),
			.i_fwd_req(arb_req[gp]), .i_fwd_data(fwd_data),
			.i_fwd_last(fwd_last), .o_fwd_take(arb_take[gp]),
			.o_tx_valid(o_tx_valid[gp]), .o_tx_data(o_tx_data[gp]),
			.o_tx_last(o_tx_last[gp]), .i_tx_ready(i_tx_ready[gp])
		);

		// Transpose requests out, takes back in
		for (genvar go = 0; go < `ROUTE_NETH; go++)
		begin : g_xpose
			assign arb_req[go][gp] = ing_req[gp][go];
			assign ing_take[gp][go] = arb_take[go][gp];
		end
	end

endmodule

`default_nettype wire

// File: source/tx_arbiter.sv
`default_nettype none
`timescale 1ns/1ns
`include "route_cfg.svh"

module tx_arbiter (
	input  wire				i_clk,
	input  wire				i_reset,
	// One request per ingress port aimed at this output
	input  wire route_pkg::port_mask_t	i_fwd_req,
	input  wire route_pkg::beat_t		i_fwd_data [0:`ROUTE_NETH-1],
	input  wire route_pkg::port_mask_t	i_fwd_last,
	output route_pkg::port_mask_t		o_fwd_take,
	// Transmit stream
	output logic				o_tx_valid,
	output route_pkg::beat_t		o_tx_data,
	output logic				o_tx_last,
	input  wire				i_tx_ready
);

	// Grant held from the first offer through the last beat
	logic				locked;
	route_pkg::port_idx_t		owner;

	route_pkg::port_idx_t		cand;
	route_pkg::port_idx_t		pick;
	logic				pick_valid;
	route_pkg::port_idx_t		sel;
	logic				tx_fire;

	////////////////////
	// Next owner
	////////////////////

	// Round-robin search starting just after the previous owner
	always_comb
	begin
		pick_valid = 1'b0;
		pick = '0;
		cand = '0;
		for (int k = 1; k <= `ROUTE_NETH; k++)
		begin
			cand = route_pkg::port_idx_t'((int'(owner) + k) % `ROUTE_NETH);
			if (!pick_valid && i_fwd_req[cand])
			begin
				pick_valid = 1'b1;
				pick = cand;
			end
		end
	end

	// Only the owner may speak while locked
	assign sel = locked ? owner : pick;

	////////////////////
	// Output mux
	////////////////////

	assign o_tx_valid = locked ? i_fwd_req[owner] : pick_valid;
	assign o_tx_data = i_fwd_data[sel];
	assign o_tx_last = i_fwd_last[sel];

	assign tx_fire = o_tx_valid && i_tx_ready;

	// Tell the chosen ingress its beat went out here
	assign o_fwd_take = tx_fire ? (route_pkg::port_mask_t'(1) << sel) : '0;

	// Lock on the first offered beat and release after the last one
	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		locked <= 1'b0;
		owner <= '0;
	end else if (o_tx_valid)
	begin
		owner <= sel;
		// A stalled beat keeps its input as well
		locked <= !(tx_fire && o_tx_last);
	end

endmodule

`default_nettype wire

// File: source/port_ingress.sv
`default_nettype none
`timescale 1ns/1ns
`include "route_cfg.svh"

module port_ingress #(
	parameter int PORT = 0
) (
	input  wire				i_clk,
	input  wire				i_reset,
	// Receive stream
	input  wire				i_rx_valid,
	input  wire route_pkg::beat_t		i_rx_data,
	input  wire				i_rx_last,
	output logic				o_rx_ready,
	// Source MAC learning
	output logic				o_learn_req,
	output route_pkg::mac_t			o_learn_mac,
	input  wire				i_learn_ack,
	// Destination lookup
	output route_pkg::mac_t			o_lkup_mac,
	input  wire				i_lkup_hit,
	input  wire route_pkg::port_idx_t	i_lkup_port,
	// Fan-out to the output arbiters
	output route_pkg::port_mask_t		o_fwd_req,
	output route_pkg::beat_t		o_fwd_data,
	output logic				o_fwd_last,
	input  wire route_pkg::port_mask_t	i_fwd_take
);

	// This port's own bit
	localparam route_pkg::port_mask_t OWN_MASK = route_pkg::port_mask_t'(1) << PORT;

	route_pkg::ingress_state_t	state;

	// Held beat and the outputs still owed it
	route_pkg::beat_t		hold_data;
	logic				hold_last;
	route_pkg::port_mask_t		rem_mask;
	route_pkg::port_mask_t		rem_after_take;
	// Destinations of the current packet
	route_pkg::port_mask_t		pkt_mask;
	route_pkg::port_mask_t		head_mask;

	logic				hold_free;
	logic				drop_head;
	logic				rx_fire;
	logic				hold_load;
	route_pkg::mac_t		src_mac;

	////////////////////
	// Head parsing
	////////////////////

	// Destination on top, source right below
	assign o_lkup_mac = i_rx_data[`ROUTE_PKTDW-1 -: `ROUTE_MACW];
	assign src_mac = i_rx_data[`ROUTE_PKTDW-`ROUTE_MACW-1 -: `ROUTE_MACW];

	// Destination lives on our own side
	assign drop_head = i_lkup_hit && (i_lkup_port == route_pkg::port_idx_t'(PORT));

	// Known station, one port; otherwise flood everyone else
	assign head_mask = i_lkup_hit ? (route_pkg::port_mask_t'(1) << i_lkup_port)
			: ~OWN_MASK;

	////////////////////
	// Flow control
	////////////////////

	// Holding register frees once every target has taken the beat
	assign rem_after_take = rem_mask & ~i_fwd_take;
	assign hold_free = (rem_after_take == '0);

	always_comb
	begin
		case (state)
		// New head waits for the previous learn to finish
		route_pkg::ING_HEAD:
			o_rx_ready = hold_free && !o_learn_req;
		route_pkg::ING_FWD:
			o_rx_ready = hold_free;
		// Dropped beats go nowhere
		default:
			o_rx_ready = 1'b1;
		endcase
	end

	assign rx_fire = i_rx_valid && o_rx_ready;

	// Beats that need forwarding
	assign hold_load = rx_fire && (state == route_pkg::ING_FWD
			|| (state == route_pkg::ING_HEAD && !drop_head));

	////////////////////
	// Packet FSM
	////////////////////

	always_ff @(posedge i_clk)
	if (i_reset)
		state <= route_pkg::ING_HEAD;
	else if (rx_fire)
	begin
		case (state)
		route_pkg::ING_HEAD:
			// Single beat packets stay put
			if (!i_rx_last)
				state <= drop_head ? route_pkg::ING_DROP : route_pkg::ING_FWD;
		default:
			if (i_rx_last)
				state <= route_pkg::ING_HEAD;
		endcase
	end

	// Learn request, held until the table writes it
	always_ff @(posedge i_clk)
	if (i_reset)
		o_learn_req <= 1'b0;
	else if (i_learn_ack)
		o_learn_req <= 1'b0;
	else if (rx_fire && state == route_pkg::ING_HEAD)
		o_learn_req <= 1'b1;

	always_ff @(posedge i_clk)
	if (rx_fire && state == route_pkg::ING_HEAD)
		o_learn_mac <= src_mac;

	////////////////////
	// Beat hold
	////////////////////

	// Remaining mask doubles as the holding register's valid
	always_ff @(posedge i_clk)
	if (i_reset)
		rem_mask <= '0;
	else if (hold_load)
		rem_mask <= (state == route_pkg::ING_HEAD) ? head_mask : pkt_mask;
	else
		rem_mask <= rem_after_take;

	always_ff @(posedge i_clk)
	if (hold_load)
	begin
		hold_data <= i_rx_data;
		hold_last <= i_rx_last;
		// Later beats reuse the head's targets
		if (state == route_pkg::ING_HEAD)
			pkt_mask <= head_mask;
	end

	assign o_fwd_req = rem_mask;
	assign o_fwd_data = hold_data;
	assign o_fwd_last = hold_last;

endmodule

`default_nettype wire

// File: source/route_table.sv
`default_nettype none
`timescale 1ns/1ns
`include "route_cfg.svh"

module route_table (
	input  wire				i_clk,
	input  wire				i_reset,
	// Learn requests, one per ingress port
	input  wire route_pkg::port_mask_t	i_learn_req,
	input  wire route_pkg::mac_t		i_learn_mac [0:`ROUTE_NETH-1],
	output route_pkg::port_mask_t		o_learn_ack,
	// Destination lookups, one per ingress port
	input  wire route_pkg::mac_t		i_lkup_mac [0:`ROUTE_NETH-1],
	output route_pkg::port_mask_t		o_lkup_hit,
	output route_pkg::port_idx_t		o_lkup_port [0:`ROUTE_NETH-1]
);

	localparam int NTBL = 2**`ROUTE_LGTBL;

	// Table storage
	logic [NTBL-1:0]		tbl_valid;
	route_pkg::mac_t		tbl_mac [0:NTBL-1];
	route_pkg::port_idx_t		tbl_port [0:NTBL-1];
	// Oldest entry, next one to be replaced
	route_pkg::tbl_idx_t		repl_ptr;

	// Learn arbitration
	route_pkg::port_idx_t		rr_last;
	route_pkg::port_idx_t		cand;
	route_pkg::port_idx_t		grant_idx;
	logic				grant_valid;

	// Existing entry for the granted source MAC
	route_pkg::tbl_idx_t		learn_idx;
	logic				learn_hit;

	////////////////////
	// Lookup
	////////////////////

	// Search every entry for every port, against the table as it stands
	always_comb
	begin
		for (int p = 0; p < `ROUTE_NETH; p++)
		begin
			o_lkup_hit[p] = 1'b0;
			o_lkup_port[p] = '0;
			for (int e = 0; e < NTBL; e++)
			begin
				// Broadcast never hits, flood instead
				if (tbl_valid[e] && tbl_mac[e] == i_lkup_mac[p]
						&& i_lkup_mac[p] != route_pkg::MAC_BROADCAST)
				begin
					o_lkup_hit[p] = 1'b1;
					o_lkup_port[p] = tbl_port[e];
				end
			end
		end
	end

	////////////////////
	// Learn arbitration
	////////////////////

	// Round-robin, first requester after the last one granted
	always_comb
	begin
		grant_valid = 1'b0;
		grant_idx = '0;
		cand = '0;
		for (int k = 1; k <= `ROUTE_NETH; k++)
		begin
			cand = route_pkg::port_idx_t'((int'(rr_last) + k) % `ROUTE_NETH);
			if (!grant_valid && i_learn_req[cand])
			begin
				grant_valid = 1'b1;
				grant_idx = cand;
			end
		end
	end

	// Ack lands in the cycle of the write
	assign o_learn_ack = grant_valid ? (route_pkg::port_mask_t'(1) << grant_idx) : '0;

	// Is the source MAC already in the table
	always_comb
	begin
		learn_hit = 1'b0;
		learn_idx = '0;
		for (int e = 0; e < NTBL; e++)
		begin
			if (tbl_valid[e] && tbl_mac[e] == i_learn_mac[grant_idx])
			begin
				learn_hit = 1'b1;
				learn_idx = route_pkg::tbl_idx_t'(e);
			end
		end
	end

	////////////////////
	// Table update
	////////////////////

	// Valid flags, replacement pointer and arbiter history
	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		tbl_valid <= '0;
		repl_ptr <= '0;
		rr_last <= '0;
	end else if (grant_valid)
	begin
		rr_last <= grant_idx;
		// New MAC takes the oldest slot
		if (!learn_hit)
		begin
			tbl_valid[repl_ptr] <= 1'b1;
			repl_ptr <= repl_ptr + 1'b1;
		end
	end

	// Entry contents
	always_ff @(posedge i_clk)
	if (grant_valid)
	begin
		if (learn_hit)
			// Station moved, keep its age
			tbl_port[learn_idx] <= grant_idx;
		else
		begin
			tbl_mac[repl_ptr] <= i_learn_mac[grant_idx];
			tbl_port[repl_ptr] <= grant_idx;
		end
	end

endmodule

`default_nettype wire

// File: source/route_pkg.sv
`default_nettype none
`include "route_cfg.svh"

package route_pkg;

	// One MAC address
	typedef logic [`ROUTE_MACW-1:0] mac_t;

	// One packet beat, always full width
	typedef logic [`ROUTE_PKTDW-1:0] beat_t;

	// One bit per switch port
	typedef logic [`ROUTE_NETH-1:0] port_mask_t;

	// Port number
	typedef logic [$clog2(`ROUTE_NETH)-1:0] port_idx_t;

	// Address table entry index
	typedef logic [`ROUTE_LGTBL-1:0] tbl_idx_t;

	// All ones, never stored as a destination
	localparam mac_t MAC_BROADCAST = '1;

	// Ingress packet state
	typedef enum logic [1:0] {
		ING_HEAD,
		ING_FWD,
		ING_DROP
	} ingress_state_t;

endpackage

`default_nettype wire

// File: include/route_cfg.svh
`ifndef ROUTE_CFG_SVH
`define ROUTE_CFG_SVH

// Number of switch ports
`define ROUTE_NETH	4

// Bits in one MAC address
`define ROUTE_MACW	48

// Bits per packet beat
// Head beat carries destination MAC on top, then the source MAC
`define ROUTE_PKTDW	128

// Log2 of the number of address table entries
`define ROUTE_LGTBL	3

`endif
